// File: rtl/bus_params_pkg.sv
package bus_params_pkg;

  typedef logic [15:0] bus_data_t;
  typedef logic [1:0] bram_select_t;
  typedef logic [13:0] bram_addr_t;

  // Upper two bits of the CPU word address.
  localparam bram_select_t BRAM_SELECT_CONTROLLER = 2'd0;
  localparam bram_select_t BRAM_SELECT_MOD = 2'd1;
  localparam bram_select_t BRAM_SELECT_STM = 2'd2;
  localparam bram_select_t BRAM_SELECT_PWE_TABLE = 2'd3;

  // Controller register map.
  localparam bram_addr_t ADDR_CTL_FLAG = 14'h0000;  // Bit 0 is mod_enable.
  localparam bram_addr_t ADDR_VERSION = 14'h0001;
  localparam bram_addr_t ADDR_MOD_MEM_WR_SEGMENT = 14'h0020;
  localparam bram_addr_t ADDR_MOD_REQ_RD_SEGMENT = 14'h0021;
  localparam bram_addr_t ADDR_MOD_CYCLE0 = 14'h0022;
  localparam bram_addr_t ADDR_MOD_FREQ_DIV0_0 = 14'h0023;  // Low half.
  localparam bram_addr_t ADDR_MOD_FREQ_DIV0_1 = 14'h0024;  // High half.
  localparam bram_addr_t ADDR_MOD_CYCLE1 = 14'h0025;
  localparam bram_addr_t ADDR_MOD_FREQ_DIV1_0 = 14'h0026;
  localparam bram_addr_t ADDR_MOD_FREQ_DIV1_1 = 14'h0027;

  localparam bus_data_t VERSION_NUM = 16'h00A2;

  // One decoded bus write, 32 bits.
  typedef struct packed {
    bram_select_t select;
    bram_addr_t   addr;
    bus_data_t    data;
  } bram_wr_t;

endpackage

// File: rtl/controller_regs.sv
module controller_regs (
  input  logic                           CPU_CKIO,
  input  logic                           rst_n,
  input  bus_params_pkg::bram_wr_t       wr,
  input  logic                           wr_valid,
  input  bus_params_pkg::bram_addr_t     rd_addr,
  input  bus_params_pkg::bram_select_t   rd_select,
  output bus_params_pkg::bus_data_t      rd_data,
  output mod_settings_pkg::mod_settings_t settings
);

  import bus_params_pkg::*;
  import mod_settings_pkg::*;

  logic      wr_hit;
  bus_data_t rd_word;

  assign wr_hit = wr_valid && (wr.select == BRAM_SELECT_CONTROLLER);

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      settings <= '0;
    end else if (wr_hit) begin
      case (wr.addr)
        ADDR_CTL_FLAG:           settings.mod_enable <= wr.data[0];
        ADDR_MOD_MEM_WR_SEGMENT: settings.mem_wr_segment <= wr.data[0];
        ADDR_MOD_REQ_RD_SEGMENT: settings.req_rd_segment <= wr.data[0];
        ADDR_MOD_CYCLE0:         settings.cycle0 <= wr.data[14:0];
        ADDR_MOD_CYCLE1:         settings.cycle1 <= wr.data[14:0];
        // Divisors are written in two halves.
        ADDR_MOD_FREQ_DIV0_0:    settings.freq_div0[15:0] <= wr.data;
        ADDR_MOD_FREQ_DIV0_1:    settings.freq_div0[31:16] <= wr.data;
        ADDR_MOD_FREQ_DIV1_0:    settings.freq_div1[15:0] <= wr.data;
        ADDR_MOD_FREQ_DIV1_1:    settings.freq_div1[31:16] <= wr.data;
        default: ;  // Version and unmapped addresses ignore writes.
      endcase
    end
  end

  // Read-back mux.
  always_comb begin
    rd_word = '0;
    case (rd_addr)
      ADDR_CTL_FLAG:           rd_word = {15'd0, settings.mod_enable};
      ADDR_VERSION:            rd_word = VERSION_NUM;
      ADDR_MOD_MEM_WR_SEGMENT: rd_word = {15'd0, settings.mem_wr_segment};
      ADDR_MOD_REQ_RD_SEGMENT: rd_word = {15'd0, settings.req_rd_segment};
      ADDR_MOD_CYCLE0:         rd_word = {1'b0, settings.cycle0};
      ADDR_MOD_CYCLE1:         rd_word = {1'b0, settings.cycle1};
      ADDR_MOD_FREQ_DIV0_0:    rd_word = settings.freq_div0[15:0];
      ADDR_MOD_FREQ_DIV0_1:    rd_word = settings.freq_div0[31:16];
      ADDR_MOD_FREQ_DIV1_0:    rd_word = settings.freq_div1[15:0];
      ADDR_MOD_FREQ_DIV1_1:    rd_word = settings.freq_div1[31:16];
      default:                 rd_word = '0;
    endcase
  end

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else begin
      rd_data <= (rd_select == BRAM_SELECT_CONTROLLER) ? rd_word : '0;
    end
  end

endmodule

// File: rtl/cpu_bus_decoder.sv
module cpu_bus_decoder (
  input  logic                        CPU_CKIO,
  input  logic                        rst_n,
  input  logic [16:0]                 cpu_addr,
  input  bus_params_pkg::bus_data_t   cpu_data_in,
  input  logic                        cpu_cn,
  input  logic                        cpu_we0_n,
  output bus_params_pkg::bram_wr_t    wr,
  output logic                        wr_valid,
  output bus_params_pkg::bram_addr_t  rd_addr,
  output bus_params_pkg::bram_select_t rd_select
);

  import bus_params_pkg::*;

  bram_select_t select_q;
  bram_addr_t   word_q;
  bus_data_t    data_q;
  logic         wr_act_q;
  logic         wr_act_d;

  // Bus sampled into the clock domain.
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      select_q <= '0;
      word_q   <= '0;
      wr_act_q <= 1'b0;
      wr_act_d <= 1'b0;
    end else begin
      select_q <= cpu_addr[16:15];
      word_q   <= cpu_addr[14:1];  // Bit 0 is always 1.
      wr_act_q <= ~cpu_cn & ~cpu_we0_n;
      wr_act_d <= wr_act_q;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    data_q <= cpu_data_in;
  end

  // One command per strobe, at its leading edge.
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= wr_act_q & ~wr_act_d;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    wr.select <= select_q;
    wr.addr   <= word_q;
    wr.data   <= data_q;
  end

  assign rd_addr   = word_q;
  assign rd_select = select_q;

endmodule

// File: rtl/mod_memory.sv
module mod_memory #(
  parameter int MOD_DEPTH = 2048
) (
  input  logic                         CPU_CKIO,
  input  bus_params_pkg::bram_wr_t     wr,
  input  logic                         wr_valid,
  input  logic                         wr_segment,
  input  logic                         rd_segment,
  input  mod_settings_pkg::mod_idx_t   rd_idx,
  output mod_settings_pkg::intensity_t rd_intensity
);

  import bus_params_pkg::*;
  import mod_settings_pkg::*;

  // Word index width inside one segment.
  localparam int WORD_W = $clog2(MOD_DEPTH / 2);

  // Even samples in the low lane, odd samples in the high lane.
  intensity_t lane_lo[MOD_DEPTH];
  intensity_t lane_hi[MOD_DEPTH];

  logic              wr_hit;
  logic [WORD_W:0]   wr_word;
  logic [WORD_W:0]   rd_word;
  intensity_t        rd_lo;
  intensity_t        rd_hi;
  logic              rd_lane_q;

  assign wr_hit  = wr_valid && (wr.select == BRAM_SELECT_MOD);
  assign wr_word = {wr_segment, wr.addr[WORD_W-1:0]};
  assign rd_word = {rd_segment, rd_idx[WORD_W:1]};

  always_ff @(posedge CPU_CKIO) begin
    if (wr_hit) begin
      lane_lo[wr_word] <= wr.data[7:0];
      lane_hi[wr_word] <= wr.data[15:8];
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    rd_lo     <= lane_lo[rd_word];
    rd_hi     <= lane_hi[rd_word];
    rd_lane_q <= rd_idx[0];
  end

  assign rd_intensity = rd_lane_q ? rd_hi : rd_lo;

endmodule

// File: rtl/mod_sample_timer.sv
module mod_sample_timer (
  input  logic                        CPU_CKIO,
  input  logic                        rst_n,
  input  logic                        start,
  input  mod_settings_pkg::freq_div_t freq_div,
  output logic                        expire
);

  import mod_settings_pkg::*;

  freq_div_t cnt;
  freq_div_t load_val;

  assign load_val = (freq_div == '0) ? freq_div_t'(1) : freq_div;  // Zero runs as one.

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      cnt    <= '0;
      expire <= 1'b0;
    end else if (start) begin
      cnt    <= load_val;
      expire <= 1'b0;
    end else if (cnt != '0) begin
      cnt    <= cnt - 1'b1;
      expire <= (cnt == freq_div_t'(1));
    end else begin
      expire <= 1'b0;  // Idle until the next start.
    end
  end

endmodule

// File: rtl/mod_sequencer.sv
module mod_sequencer #(
  parameter int MOD_DEPTH = 2048
) (
  input  logic                            CPU_CKIO,
  input  logic                            rst_n,
  input  mod_settings_pkg::mod_settings_t settings,
  input  logic                            expire,
  input  mod_settings_pkg::intensity_t    rd_intensity,
  input  logic                            sample_ready,
  output logic                            start,
  output mod_settings_pkg::freq_div_t     freq_div,
  output logic                            rd_segment,
  output mod_settings_pkg::mod_idx_t      rd_idx,
  output mod_settings_pkg::mod_sample_t   sample,
  output logic                            sample_valid
);

  import mod_settings_pkg::*;

  localparam mod_idx_t LAST_IDX = mod_idx_t'(MOD_DEPTH - 1);

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    PRESENT,
    WAIT_TICK
  } state_t;

  state_t   state;
  logic     seg_q;
  mod_idx_t idx_q;
  logic     transfer;
  logic     fetch_seg;
  mod_idx_t fetch_idx;
  mod_idx_t cycle_sel;
  mod_idx_t next_idx;

  assign transfer = sample_valid & sample_ready;
  assign start    = transfer;

  // Active segment parameters.
  assign cycle_sel = seg_q ? settings.cycle1 : settings.cycle0;
  assign freq_div  = seg_q ? settings.freq_div1 : settings.freq_div0;
  assign next_idx  = (idx_q >= cycle_sel || idx_q >= LAST_IDX) ? '0 : idx_q + 1'b1;

  // Address of the next fetch; a new segment starts from index 0.
  assign fetch_seg = settings.req_rd_segment;
  assign fetch_idx = (state == IDLE || fetch_seg != seg_q) ? '0 : idx_q;

  assign rd_segment = fetch_seg;
  assign rd_idx     = fetch_idx;

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      state        <= IDLE;
      seg_q        <= 1'b0;
      idx_q        <= '0;
      sample_valid <= 1'b0;
    end else if (!settings.mod_enable) begin
      state        <= IDLE;
      idx_q        <= '0;
      sample_valid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          seg_q <= fetch_seg;
          idx_q <= fetch_idx;
          state <= FETCH;
        end
        FETCH: begin  // Memory output valid here.
          sample_valid <= 1'b1;
          state        <= PRESENT;
        end
        PRESENT: begin
          if (transfer) begin
            sample_valid <= 1'b0;
            idx_q        <= next_idx;
            state        <= WAIT_TICK;
          end
        end
        WAIT_TICK: begin
          if (expire) begin
            seg_q <= fetch_seg;
            idx_q <= fetch_idx;
            state <= FETCH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Held until the transfer.
  always_ff @(posedge CPU_CKIO) begin
    if (state == FETCH) begin
      sample.segment   <= seg_q;
      sample.idx       <= idx_q;
      sample.intensity <= rd_intensity;
    end
  end

endmodule

// File: rtl/mod_settings_pkg.sv
package mod_settings_pkg;

  typedef logic [7:0] intensity_t;
  typedef logic [14:0] mod_idx_t;
  typedef logic [31:0] freq_div_t;

  // Modulation settings as held by the controller.
  typedef struct packed {
    logic      mod_enable;
    logic      mem_wr_segment;
    logic      req_rd_segment;
    mod_idx_t  cycle0;  // Last index of segment 0.
    mod_idx_t  cycle1;  // Last index of segment 1.
    freq_div_t freq_div0;
    freq_div_t freq_div1;
  } mod_settings_t;

  // One output sample.
  typedef struct packed {
    logic       segment;
    mod_idx_t   idx;
    intensity_t intensity;
  } mod_sample_t;

endpackage

// File: rtl/mod_subsystem_top.sv
module mod_subsystem_top #(
  parameter int MOD_DEPTH = 2048
) (
  input  logic                          CPU_CKIO,
  input  logic                          rst_n,
  input  logic [16:0]                   cpu_addr,
  input  bus_params_pkg::bus_data_t     cpu_data_in,
  input  logic                          cpu_cn,
  input  logic                          cpu_we0_n,
  output bus_params_pkg::bus_data_t     cpu_data_out,
  output mod_settings_pkg::mod_sample_t sample,
  output logic                          sample_valid,
  input  logic                          sample_ready
);

  import bus_params_pkg::*;
  import mod_settings_pkg::*;

  bram_wr_t      wr;
  logic          wr_valid;
  bram_addr_t    rd_addr;
  bram_select_t  rd_select;
  mod_settings_t settings;
  logic          start;
  freq_div_t     freq_div;
  logic          expire;
  logic          rd_segment;
  mod_idx_t      rd_idx;
  intensity_t    rd_intensity;

  cpu_bus_decoder i_cpu_bus_decoder (
    .CPU_CKIO   (CPU_CKIO),
    .rst_n      (rst_n),
    .cpu_addr   (cpu_addr),
    .cpu_data_in(cpu_data_in),
    .cpu_cn     (cpu_cn),
    .cpu_we0_n  (cpu_we0_n),
    .wr         (wr),
    .wr_valid   (wr_valid),
    .rd_addr    (rd_addr),
    .rd_select  (rd_select)
  );

  controller_regs i_controller_regs (
    .CPU_CKIO (CPU_CKIO),
    .rst_n    (rst_n),
    .wr       (wr),
    .wr_valid (wr_valid),
    .rd_addr  (rd_addr),
    .rd_select(rd_select),
    .rd_data  (cpu_data_out),
    .settings (settings)
  );

  mod_memory #(
    .MOD_DEPTH(MOD_DEPTH)
  ) i_mod_memory (
    .CPU_CKIO    (CPU_CKIO),
    .wr          (wr),
    .wr_valid    (wr_valid),
    .wr_segment  (settings.mem_wr_segment),
    .rd_segment  (rd_segment),
    .rd_idx      (rd_idx),
    .rd_intensity(rd_intensity)
  );

  mod_sample_timer i_mod_sample_timer (
    .CPU_CKIO(CPU_CKIO),
    .rst_n   (rst_n),
    .start   (start),
    .freq_div(freq_div),
    .expire  (expire)
  );

  mod_sequencer #(
    .MOD_DEPTH(MOD_DEPTH)
  ) i_mod_sequencer (
    .CPU_CKIO    (CPU_CKIO),
    .rst_n       (rst_n),
    .settings    (settings),
    .expire      (expire),
    .rd_intensity(rd_intensity),
    .sample_ready(sample_ready),
    .start       (start),
    .freq_div    (freq_div),
    .rd_segment  (rd_segment),
    .rd_idx      (rd_idx),
    .sample      (sample),
    .sample_valid(sample_valid)
  );

endmodule

// File: tb.f
+incdir+verification
rtl/bus_params_pkg.sv
rtl/mod_settings_pkg.sv
rtl/cpu_bus_decoder.sv
rtl/controller_regs.sv
rtl/mod_memory.sv
rtl/mod_sample_timer.sv
rtl/mod_sequencer.sv
rtl/mod_subsystem_top.sv
verification/clock_gen.sv
verification/mod_tb.sv

// File: verification/clock_gen.sv
module clock_gen (
  output logic CPU_CKIO,
  output logic rst_n
);

  localparam int HALF_PERIOD = 10;

  initial begin
    CPU_CKIO = 1'b0;
    forever #HALF_PERIOD CPU_CKIO = ~CPU_CKIO;
  end

  // Reset held for 10 cycles, released on a falling edge.
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge CPU_CKIO);
    @(negedge CPU_CKIO);
    rst_n = 1'b1;
  end

endmodule

// File: verification/cpu_bus_tasks.svh
`ifndef CPU_BUS_TASKS_SVH
`define CPU_BUS_TASKS_SVH

// Called on a falling edge, returns on a falling edge once the write is visible.
task automatic bus_write(input bram_select_t sel, input bram_addr_t addr, input bus_data_t data);
  cpu_addr    = {sel, addr, 1'b1};
  cpu_data_in = data;
  cpu_cn      = 1'b0;
  @(negedge CPU_CKIO);
  cpu_we0_n = 1'b0;  // Strobe low for two cycles.
  repeat (2) @(negedge CPU_CKIO);
  cpu_we0_n = 1'b1;
  cpu_cn    = 1'b1;
  repeat (3) @(negedge CPU_CKIO);
endtask

task automatic bus_read(input bram_select_t sel, input bram_addr_t addr,
                        output bus_data_t data);
  cpu_addr = {sel, addr, 1'b1};
  cpu_cn   = 1'b0;
  repeat (3) @(negedge CPU_CKIO);
  data   = cpu_data_out;
  cpu_cn = 1'b1;
  @(negedge CPU_CKIO);
endtask

// Random words into one segment, with the expected bytes kept per index.
task automatic load_segment(input logic seg, input int num_words);
  bus_data_t word;
  bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, {15'd0, seg});
  for (int w = 0; w < num_words; w++) begin
    word = bus_data_t'($urandom);
    bus_write(BRAM_SELECT_MOD, bram_addr_t'(w), word);
    seg_bytes[seg][2 * w]     = word[7:0];
    seg_bytes[seg][2 * w + 1] = word[15:8];
  end
endtask

task automatic set_divisor(input logic seg, input freq_div_t value);
  bus_write(BRAM_SELECT_CONTROLLER, seg ? ADDR_MOD_FREQ_DIV1_0 : ADDR_MOD_FREQ_DIV0_0,
            value[15:0]);
  bus_write(BRAM_SELECT_CONTROLLER, seg ? ADDR_MOD_FREQ_DIV1_1 : ADDR_MOD_FREQ_DIV0_1,
            value[31:16]);
endtask

task automatic set_enable(input logic en);
  bus_write(BRAM_SELECT_CONTROLLER, ADDR_CTL_FLAG, {15'd0, en});
endtask

`endif

// File: verification/mod_tb.sv
module mod_tb;

  import bus_params_pkg::*;
  import mod_settings_pkg::*;

  // Worst-case cycles per test.
  localparam int T1_CYCLES = 200;
  localparam int T2_CYCLES = 200;
  localparam int T3_CYCLES = 450;
  localparam int T4_CYCLES = 100;
  localparam int T5_CYCLES = 200;
  localparam int T6_CYCLES = 60;
  localparam int RUN_LIMIT = 2 * (T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                                  + T5_CYCLES + T6_CYCLES);

  logic        CPU_CKIO;
  logic        rst_n;
  logic [16:0] cpu_addr;
  bus_data_t   cpu_data_in;
  logic        cpu_cn;
  logic        cpu_we0_n;
  bus_data_t   cpu_data_out;
  mod_sample_t sample;
  logic        sample_valid;
  logic        sample_ready;

  intensity_t  seg_bytes[2][16];  // Expected bytes per segment.
  mod_sample_t rx_q[$];
  int unsigned rx_time_q[$];
  int unsigned cycle_count = 0;
  int          errors = 0;
  int          test_errors_at_start;
  int          tests_passed = 0;
  int          tests_failed = 0;
  string       test_name = "reset";
  logic        hold_check = 1'b0;
  logic        held_q = 1'b0;
  mod_sample_t held_sample;

  clock_gen i_clock_gen (
    .CPU_CKIO(CPU_CKIO),
    .rst_n   (rst_n)
  );

  mod_subsystem_top i_mod_subsystem_top (
    .CPU_CKIO    (CPU_CKIO),
    .rst_n       (rst_n),
    .cpu_addr    (cpu_addr),
    .cpu_data_in (cpu_data_in),
    .cpu_cn      (cpu_cn),
    .cpu_we0_n   (cpu_we0_n),
    .cpu_data_out(cpu_data_out),
    .sample      (sample),
    .sample_valid(sample_valid),
    .sample_ready(sample_ready)
  );

  `include "cpu_bus_tasks.svh"

  // Transfer monitor and hold check.
  always @(posedge CPU_CKIO) begin
    cycle_count++;
    if (hold_check && held_q) begin
      assert (sample_valid === 1'b1 && sample === held_sample) else begin
        $display("%s: a held sample changed or was dropped before its transfer", test_name);
        errors++;
      end
    end
    held_q      = (sample_valid === 1'b1) && (sample_ready === 1'b0);
    held_sample = sample;
    if (sample_valid === 1'b1 && sample_ready === 1'b1) begin
      rx_q.push_back(sample);
      rx_time_q.push_back(cycle_count);
    end
  end

  initial begin
    wait (cycle_count >= RUN_LIMIT);
    $display("Timeout: run stopped after %0d cycles", cycle_count);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH %s: expected %0h, actual %0h", test_name, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors_at_start = errors;
    rx_q.delete();
    rx_time_q.delete();
  endtask

  task automatic finish_test();
    if (errors == test_errors_at_start) begin
      $display("%s: passed", test_name);
      tests_passed++;
    end else begin
      $display("%s: failed with %0d errors", test_name, errors - test_errors_at_start);
      tests_failed++;
    end
  endtask

  task automatic wait_samples(input int count, input int limit);
    int unsigned t0;
    t0 = cycle_count;
    while (rx_q.size() < count && cycle_count - t0 < limit) @(negedge CPU_CKIO);
    assert (rx_q.size() >= count) else begin
      $display("%s: only %0d of %0d samples arrived", test_name, rx_q.size(), count);
      errors++;
    end
  endtask

  // Checks seg/idx/intensity of queued samples, from queue entry first.
  task automatic check_playback(input int first, input logic seg, input int last_idx);
    int i;
    for (int k = first; k < rx_q.size(); k++) begin
      i = (k - first) % (last_idx + 1);
      check_value(seg, rx_q[k].segment);
      check_value(i, rx_q[k].idx);
      check_value(seg_bytes[seg][i], rx_q[k].intensity);
    end
  endtask

  task automatic test_register_readback();
    bram_addr_t addrs[9];
    bus_data_t  masks[9];
    bus_data_t  expected[9];
    bus_data_t  data;
    start_test("register_readback");
    addrs = '{ADDR_CTL_FLAG, ADDR_MOD_MEM_WR_SEGMENT, ADDR_MOD_REQ_RD_SEGMENT,
              ADDR_MOD_CYCLE0, ADDR_MOD_CYCLE1, ADDR_MOD_FREQ_DIV0_0, ADDR_MOD_FREQ_DIV0_1,
              ADDR_MOD_FREQ_DIV1_0, ADDR_MOD_FREQ_DIV1_1};
    masks = '{16'h0001, 16'h0001, 16'h0001, 16'h7FFF, 16'h7FFF,
              16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF};
    for (int i = 0; i < 9; i++) begin
      data = bus_data_t'($urandom);
      expected[i] = data & masks[i];
      bus_write(BRAM_SELECT_CONTROLLER, addrs[i], data);
    end
    for (int i = 0; i < 9; i++) begin
      bus_read(BRAM_SELECT_CONTROLLER, addrs[i], data);
      check_value(expected[i], data);
    end
    bus_read(BRAM_SELECT_CONTROLLER, ADDR_VERSION, data);
    check_value(VERSION_NUM, data);
    // STM writes are dropped, STM reads are zero.
    bus_write(BRAM_SELECT_STM, ADDR_MOD_CYCLE0, ~expected[3]);
    bus_read(BRAM_SELECT_CONTROLLER, ADDR_MOD_CYCLE0, data);
    check_value(expected[3], data);
    bus_read(BRAM_SELECT_STM, ADDR_MOD_CYCLE0, data);
    check_value(0, data);
    set_enable(1'b0);
    finish_test();
  endtask

  task automatic test_packing_playback();
    start_test("packing_playback");
    load_segment(1'b0, 5);
    bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_CYCLE0, 16'd9);
    bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_REQ_RD_SEGMENT, 16'd0);
    set_divisor(1'b0, 32'd4);
    sample_ready = 1'b1;
    rx_q.delete();
    rx_time_q.delete();
    set_enable(1'b1);
    wait_samples(11, T2_CYCLES);
    check_playback(0, 1'b0, 9);
    finish_test();
  endtask

  task automatic test_back_pressure();
    int unsigned t0;
    int unsigned stretch;
    logic        level;
    start_test("back_pressure");
    set_enable(1'b0);
    sample_ready = 1'b0;
    level = 1'b0;
    rx_q.delete();
    rx_time_q.delete();
    set_enable(1'b1);
    hold_check = 1'b1;
    t0 = cycle_count;
    while (rx_q.size() < 20 && cycle_count - t0 < T3_CYCLES) begin
      stretch = 1 + $urandom % 6;
      level = ~level;
      sample_ready = level;
      repeat (stretch) @(negedge CPU_CKIO);
    end
    sample_ready = 1'b0;
    hold_check = 1'b0;
    wait_samples(20, 1);
    check_playback(0, 1'b0, 9);
    finish_test();
  endtask

  task automatic test_sample_spacing();
    int unsigned gap;
    start_test("sample_spacing");
    set_divisor(1'b0, 32'd6);
    rx_q.delete();
    rx_time_q.delete();
    sample_ready = 1'b1;
    wait_samples(8, T4_CYCLES);
    for (int k = 1; k < rx_time_q.size(); k++) begin
      gap = rx_time_q[k] - rx_time_q[k - 1];
      assert (gap >= 6) else begin
        $display("%s: only %0d clocks between transfers, at least 6 expected", test_name, gap);
        errors++;
      end
    end
    finish_test();
  endtask

  task automatic test_segment_switch();
    int lead;
    start_test("segment_switch");
    load_segment(1'b1, 4);
    bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_CYCLE1, 16'd7);
    set_divisor(1'b1, 32'd3);
    bus_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_REQ_RD_SEGMENT, 16'd1);
    rx_q.delete();
    rx_time_q.delete();
    wait_samples(10, T5_CYCLES);
    lead = 0;
    while (lead < rx_q.size() && rx_q[lead].segment == 1'b0) lead++;
    // One segment 0 sample may already be in flight.
    assert (lead <= 1) else begin
      $display("%s: %0d segment 0 samples after the switch", test_name, lead);
      errors++;
    end
    check_playback(lead, 1'b1, 7);
    finish_test();
  endtask

  task automatic test_disable_enable();
    int unsigned t0;
    start_test("disable_enable");
    sample_ready = 1'b0;  // A held sample keeps valid high until the disable.
    t0 = cycle_count;
    while (sample_valid !== 1'b1 && cycle_count - t0 < T6_CYCLES) @(negedge CPU_CKIO);
    assert (sample_valid === 1'b1) else begin
      $display("%s: no sample became valid before the disable", test_name);
      errors++;
    end
    set_enable(1'b0);
    check_value(0, sample_valid);
    sample_ready = 1'b1;
    rx_q.delete();
    rx_time_q.delete();
    set_enable(1'b1);
    wait_samples(3, T6_CYCLES);
    check_playback(0, 1'b1, 7);
    finish_test();
  endtask

  initial begin
    void'($urandom(7771));
    cpu_addr     = '0;
    cpu_data_in  = '0;
    cpu_cn       = 1'b1;
    cpu_we0_n    = 1'b1;
    sample_ready = 1'b0;
    wait (rst_n === 1'b1);
    @(negedge CPU_CKIO);
    test_register_readback();
    test_packing_playback();
    test_back_pressure();
    test_sample_spacing();
    test_segment_switch();
    test_disable_enable();
    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
